// File: logic/cpu_pkg.sv
package cpu_pkg;

    // data path and address width
    localparam int xlen       = 32;
    // register number width, 32 architectural registers
    localparam int reg_addr_w = 5;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc   = 32'h0000_0000;
    // fetch target once an illegal opcode reaches writeback
    localparam logic [xlen-1:0] exc_vector = 32'h0000_0100;

    // major opcodes in bits 31..26
    // register-register ops reuse the mips funct values
    typedef enum logic [5:0] {
        op_beq  = 6'h04,
        op_bne  = 6'h05,
        op_addi = 6'h08,
        op_lui  = 6'h0f,
        op_add  = 6'h20,
        op_sub  = 6'h22,
        op_lw   = 6'h23,
        op_and  = 6'h24,
        op_or   = 6'h25,
        op_xor  = 6'h26,
        op_slt  = 6'h2a,
        op_sw   = 6'h2b
    } opcode_e;

endpackage

// File: logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                           clk,
    input  logic                           arst_n,
    // instruction sram, read only
    output logic                           inst_sram_en,
    output logic [cpu_pkg::xlen-1:0]       inst_sram_addr,
    input  logic [cpu_pkg::xlen-1:0]       inst_sram_rdata,
    // data sram
    output logic                           data_sram_en,
    output logic [3:0]                     data_sram_wen,
    output logic [cpu_pkg::xlen-1:0]       data_sram_addr,
    output logic [cpu_pkg::xlen-1:0]       data_sram_wdata,
    input  logic [cpu_pkg::xlen-1:0]       data_sram_rdata,
    // write-back trace
    output logic [cpu_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                     debug_wb_rf_wen,
    output logic [cpu_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_rf_wdata
);
    import cpu_pkg::*;

    // fetch to execute
    logic                  fs_valid;
    logic [xlen-1:0]       fs_pc;
    logic [xlen-1:0]       fs_inst;
    logic                  br_taken;
    logic [xlen-1:0]       br_target;
    // execute to writeback
    logic                  es_valid;
    logic [xlen-1:0]       es_pc;
    opcode_e               es_op;
    logic [reg_addr_w-1:0] es_dest;
    logic [xlen-1:0]       es_result;
    logic                  es_wen;
    logic                  es_is_load;
    logic                  es_exc;
    // register file
    logic [reg_addr_w-1:0] rs_addr;
    logic [reg_addr_w-1:0] rt_addr;
    logic [xlen-1:0]       rs_data;
    logic [xlen-1:0]       rt_data;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;
    logic                  ex_flush;

    fetch_stage fetch_stage_inst (
        .clk             (clk),
        .arst_n          (arst_n),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .ex_flush        (ex_flush),
        .inst_sram_rdata (inst_sram_rdata),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .fs_valid        (fs_valid),
        .fs_pc           (fs_pc),
        .fs_inst         (fs_inst)
    );

    exe_stage exe_stage_inst (
        .clk             (clk),
        .arst_n          (arst_n),
        .fs_valid        (fs_valid),
        .fs_pc           (fs_pc),
        .fs_inst         (fs_inst),
        .rs_data         (rs_data),
        .rt_data         (rt_data),
        .ex_flush        (ex_flush),
        .rs_addr         (rs_addr),
        .rt_addr         (rt_addr),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .data_sram_en    (data_sram_en),
        .data_sram_wen   (data_sram_wen),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .es_valid        (es_valid),
        .es_pc           (es_pc),
        .es_op           (es_op),
        .es_dest         (es_dest),
        .es_result       (es_result),
        .es_wen          (es_wen),
        .es_is_load      (es_is_load),
        .es_exc          (es_exc)
    );

    wb_stage wb_stage_inst (
        .clk               (clk),
        .arst_n            (arst_n),
        .es_valid          (es_valid),
        .es_pc             (es_pc),
        .es_op             (es_op),
        .es_dest           (es_dest),
        .es_result         (es_result),
        .es_wen            (es_wen),
        .es_is_load        (es_is_load),
        .es_exc            (es_exc),
        .data_sram_rdata   (data_sram_rdata),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .ex_flush          (ex_flush),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

endmodule

// File: logic/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           fs_valid,
    input  logic [cpu_pkg::xlen-1:0]       fs_pc,
    input  logic [cpu_pkg::xlen-1:0]       fs_inst,
    input  logic [cpu_pkg::xlen-1:0]       rs_data,
    input  logic [cpu_pkg::xlen-1:0]       rt_data,
    input  logic                           ex_flush,
    output logic [cpu_pkg::reg_addr_w-1:0] rs_addr,
    output logic [cpu_pkg::reg_addr_w-1:0] rt_addr,
    output logic                           br_taken,
    output logic [cpu_pkg::xlen-1:0]       br_target,
    output logic                           data_sram_en,
    output logic [3:0]                     data_sram_wen,
    output logic [cpu_pkg::xlen-1:0]       data_sram_addr,
    output logic [cpu_pkg::xlen-1:0]       data_sram_wdata,
    output logic                           es_valid,
    output logic [cpu_pkg::xlen-1:0]       es_pc,
    output cpu_pkg::opcode_e               es_op,
    output logic [cpu_pkg::reg_addr_w-1:0] es_dest,
    output logic [cpu_pkg::xlen-1:0]       es_result,
    output logic                           es_wen,
    output logic                           es_is_load,
    output logic                           es_exc
);
    import cpu_pkg::*;

    opcode_e               op;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       simm;
    logic [xlen-1:0]       mem_addr;
    logic [xlen-1:0]       alu_result;
    logic [reg_addr_w-1:0] dest;
    logic                  wen;
    logic                  is_load;
    logic                  is_store;
    logic                  br_cond;
    logic                  exc;
    logic                  go;

    // field split
    assign op      = opcode_e'(fs_inst[31:26]);
    assign rs_addr = fs_inst[25:21];
    assign rt      = fs_inst[20:16];
    assign rd      = fs_inst[15:11];
    assign rt_addr = rt;
    assign simm    = {{(xlen-16){fs_inst[15]}}, fs_inst[15:0]};

    assign mem_addr = rs_data + simm;

    // an older exception in writeback kills this slot
    assign go = fs_valid & ~ex_flush;

    always_comb begin
        alu_result = '0;
        dest       = rd;
        wen        = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        br_cond    = 1'b0;
        exc        = 1'b0;
        case (op)
            op_add: begin
                alu_result = rs_data + rt_data;
                wen        = 1'b1;
            end
            op_sub: begin
                alu_result = rs_data - rt_data;
                wen        = 1'b1;
            end
            op_and: begin
                alu_result = rs_data & rt_data;
                wen        = 1'b1;
            end
            op_or: begin
                alu_result = rs_data | rt_data;
                wen        = 1'b1;
            end
            op_xor: begin
                alu_result = rs_data ^ rt_data;
                wen        = 1'b1;
            end
            op_slt: begin
                alu_result = {{(xlen-1){1'b0}}, $signed(rs_data) < $signed(rt_data)};
                wen        = 1'b1;
            end
            op_addi: begin
                alu_result = rs_data + simm;
                dest       = rt;
                wen        = 1'b1;
            end
            op_lui: begin
                alu_result = {fs_inst[15:0], {(xlen-16){1'b0}}};
                dest       = rt;
                wen        = 1'b1;
            end
            op_lw: begin
                alu_result = mem_addr;
                dest       = rt;
                wen        = 1'b1;
                is_load    = 1'b1;
            end
            op_sw: is_store = 1'b1;
            op_beq: br_cond = (rs_data == rt_data);
            op_bne: br_cond = (rs_data != rt_data);
            default: exc = 1'b1;
        endcase
    end

    // data sram request in the execute cycle
    assign data_sram_en    = go & (is_load | is_store);
    assign data_sram_wen   = (go & is_store) ? 4'hf : 4'h0;
    assign data_sram_addr  = mem_addr;
    assign data_sram_wdata = rt_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            es_valid <= 1'b0;
            br_taken <= 1'b0;
        end else begin
            es_valid <= go;
            br_taken <= go & br_cond;
        end
    end

    always_ff @(posedge clk) begin
        es_pc      <= fs_pc;
        es_op      <= op;
        es_dest    <= dest;
        es_result  <= alu_result;
        es_wen     <= wen & ~exc;
        es_is_load <= is_load;
        es_exc     <= exc;
        // target relative to the slot after the branch
        br_target  <= fs_pc + xlen'(4) + {simm[xlen-3:0], 2'b00};
    end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     br_taken,
    input  logic [cpu_pkg::xlen-1:0] br_target,
    input  logic                     ex_flush,
    input  logic [cpu_pkg::xlen-1:0] inst_sram_rdata,
    output logic                     inst_sram_en,
    output logic [cpu_pkg::xlen-1:0] inst_sram_addr,
    output logic                     fs_valid,
    output logic [cpu_pkg::xlen-1:0] fs_pc,
    output logic [cpu_pkg::xlen-1:0] fs_inst
);
    import cpu_pkg::*;

    // pc of the instruction whose data is on inst_sram_rdata
    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;
    logic            fetched;

    // exception redirect wins over a branch
    always_comb begin
        if (ex_flush) begin
            next_pc = exc_vector;
        end else if (br_taken) begin
            next_pc = br_target;
        end else begin
            next_pc = pc + xlen'(4);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // first request after reset lands on reset_pc
            pc      <= reset_pc - xlen'(4);
            fetched <= 1'b0;
        end else begin
            pc      <= next_pc;
            fetched <= 1'b1;
        end
    end

    // sram has a fixed one-cycle latency, the read port is always on
    assign inst_sram_en   = 1'b1;
    assign inst_sram_addr = next_pc;

    // returning word was requested before the taken branch resolved
    assign fs_valid = fetched & ~br_taken;
    assign fs_pc    = pc;
    assign fs_inst  = inst_sram_rdata;

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [cpu_pkg::reg_addr_w-1:0] rt_addr,
    input  logic                           we,
    input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
    input  logic [cpu_pkg::xlen-1:0]       wdata,
    output logic [cpu_pkg::xlen-1:0]       rs_data,
    output logic [cpu_pkg::xlen-1:0]       rt_data
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];
    logic            wr_live;

    // register 0 never takes a write
    assign wr_live = we && (waddr != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write goes straight through to the readers
    assign rs_data = (wr_live && (rs_addr == waddr)) ? wdata : regs[rs_addr];
    assign rt_data = (wr_live && (rt_addr == waddr)) ? wdata : regs[rt_addr];

endmodule

// File: logic/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           es_valid,
    input  logic [cpu_pkg::xlen-1:0]       es_pc,
    input  cpu_pkg::opcode_e               es_op,
    input  logic [cpu_pkg::reg_addr_w-1:0] es_dest,
    input  logic [cpu_pkg::xlen-1:0]       es_result,
    input  logic                           es_wen,
    input  logic                           es_is_load,
    input  logic                           es_exc,
    input  logic [cpu_pkg::xlen-1:0]       data_sram_rdata,
    output logic                           rf_we,
    output logic [cpu_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [cpu_pkg::xlen-1:0]       rf_wdata,
    output logic                           ex_flush,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                     debug_wb_rf_wen,
    output logic [cpu_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic            ld_word;
    logic [xlen-1:0] last_pc;

    // only word loads exist, so the full read word is taken
    assign ld_word = es_is_load && (es_op == op_lw);

    // writes to register 0 retire without a trace
    assign rf_we    = es_valid & es_wen & ~es_exc & (es_dest != '0);
    assign rf_waddr = es_dest;
    assign rf_wdata = ld_word ? data_sram_rdata : es_result;

    // younger slots are dropped and fetch jumps to the vector
    assign ex_flush = es_valid & es_exc;

    // pc of the last traced write, held while nothing retires
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_pc <= reset_pc;
        end else if (rf_we) begin
            last_pc <= es_pc;
        end
    end

    assign debug_wb_pc       = rf_we ? es_pc : last_pc;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// File: verif/cpu_props.sv
`timescale 1ns/1ps

module cpu_props (
    input logic       clk,
    input logic       arst_n,
    input logic       fs_valid,
    input logic       es_valid,
    input logic       ex_flush,
    input logic [3:0] data_sram_wen,
    input logic [3:0] debug_wb_rf_wen
);
    // failures seen so far, read by the testbench at the end
    int assert_fails = 0;

    // a slot killed by the exception must not reach the data sram
    no_store_in_flush: assert property (
        @(posedge clk) disable iff (!arst_n) ex_flush |-> (data_sram_wen == 4'h0)
    ) else begin
        $error("store issued while an exception flush is active");
        assert_fails++;
    end

    // trace enable is all or nothing
    trace_wen_whole: assert property (
        @(posedge clk) disable iff (!arst_n)
            (debug_wb_rf_wen == 4'h0) || (debug_wb_rf_wen == 4'hf)
    ) else begin
        $error("trace write enable is neither 0 nor f");
        assert_fails++;
    end

    // pipeline starts empty once reset is released
    empty_after_reset: assert property (
        @(posedge clk) $rose(arst_n) |-> (!fs_valid && !es_valid)
    ) else begin
        $error("valid bit set in the first cycle after reset");
        assert_fails++;
    end

endmodule

bind cpu_top cpu_props cpu_props_inst (
    .clk             (clk),
    .arst_n          (arst_n),
    .fs_valid        (fs_valid),
    .es_valid        (es_valid),
    .ex_flush        (ex_flush),
    .data_sram_wen   (data_sram_wen),
    .debug_wb_rf_wen (debug_wb_rf_wen)
);

// File: verif/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int retire_target = 2000;
    localparam int cycle_limit   = 3 * retire_target + 100;

    logic        clk;
    logic        arst_n;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    logic [31:0] ref_dmem [64];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    logic [31:0] lfsr_state;
    // wen, address and write data of every data port access
    logic [67:0] access_q [$];
    int          retired;
    int          checks;
    int          value_errors;
    int          other_errors;
    int          cycle_count;

    cpu_top cpu_top_inst (
        .clk               (clk),
        .arst_n            (arst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #4 clk = ~clk;

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // registers 0..7 only, so dependences and r0 writes are frequent
    function automatic logic [31:0] make_instruction(input int idx);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [3:0]  kind;
        rs  = 5'(take_bits(3));
        rt  = 5'(take_bits(3));
        rd  = 5'(take_bits(3));
        imm = 16'(take_bits(16));
        // the words at the vector always write, so exception loops still retire
        if (idx >= int'(exc_vector[9:2]) && idx < int'(exc_vector[9:2]) + 8) begin
            return {op_addi, rs, 5'(take_bits(3) % 7 + 1), imm};
        end
        if (take_bits(5) == 0) begin
            return {6'h3f, 26'(take_bits(26))};
        end
        kind = 4'(take_bits(4));
        case (kind)
            0: return {op_add, rs, rt, rd, 11'd0};
            1: return {op_sub, rs, rt, rd, 11'd0};
            2: return {op_and, rs, rt, rd, 11'd0};
            3: return {op_or, rs, rt, rd, 11'd0};
            4: return {op_xor, rs, rt, rd, 11'd0};
            5: return {op_slt, rs, rt, rd, 11'd0};
            6, 15: return {op_addi, rs, rt, imm};
            7: return {op_lui, 5'd0, rt, imm};
            8, 9, 10: return {op_lw, 5'd0, rt, 8'd0, 6'(take_bits(6)), 2'b00};
            11, 12: return {op_sw, 5'd0, rt, 8'd0, 6'(take_bits(6)), 2'b00};
            // forward offsets only, no tight loops
            13: return {op_beq, rs, rt, 16'(take_bits(3) + 1)};
            default: return {op_bne, rs, rt, 16'(take_bits(3) + 1)};
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_access(input logic store, input logic [31:0] addr,
                                input logic [31:0] wdata);
        logic [67:0] seen;
        if (access_q.size() == 0) begin
            other_errors++;
            $display("no data port access was seen for the memory op at pc %h", ref_pc);
        end else begin
            seen = access_q.pop_front();
            compare_value("data_sram_wen", 32'(seen[67:64]), store ? 32'hf : 32'h0);
            compare_value("data_sram_addr", seen[63:32], addr);
            if (store) begin
                compare_value("data_sram_wdata", seen[31:0], wdata);
            end
        end
    endtask

    // run the model up to its next register write and compare with the trace
    task automatic follow_retirement();
        logic [31:0] inst;
        logic [31:0] rs_v;
        logic [31:0] rt_v;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] result;
        logic [31:0] next_pc;
        logic [4:0]  dest;
        logic        writes;
        logic        done;
        int          steps;
        done  = 1'b0;
        steps = 0;
        while (!done) begin
            inst    = imem[ref_pc[9:2]];
            rs_v    = ref_regs[inst[25:21]];
            rt_v    = ref_regs[inst[20:16]];
            simm    = {{16{inst[15]}}, inst[15:0]};
            addr    = rs_v + simm;
            result  = '0;
            writes  = 1'b1;
            next_pc = ref_pc + 32'd4;
            dest    = inst[20:16];
            if (inst[31:26] inside {op_add, op_sub, op_and, op_or, op_xor, op_slt}) begin
                dest = inst[15:11];
            end
            case (inst[31:26])
                op_add:  result = rs_v + rt_v;
                op_sub:  result = rs_v - rt_v;
                op_and:  result = rs_v & rt_v;
                op_or:   result = rs_v | rt_v;
                op_xor:  result = rs_v ^ rt_v;
                op_slt:  result = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
                op_addi: result = addr;
                op_lui:  result = {inst[15:0], 16'h0000};
                op_lw: begin
                    check_access(1'b0, addr, '0);
                    result = ref_dmem[addr[7:2]];
                end
                op_sw: begin
                    writes = 1'b0;
                    check_access(1'b1, addr, rt_v);
                    ref_dmem[addr[7:2]] = rt_v;
                end
                op_beq, op_bne: begin
                    writes = 1'b0;
                    if ((rs_v == rt_v) == (inst[31:26] == op_beq)) begin
                        next_pc = ref_pc + 32'd4 + {simm[29:0], 2'b00};
                    end
                end
                default: begin
                    writes  = 1'b0;
                    next_pc = exc_vector;
                end
            endcase
            if (writes && dest != 5'd0) begin
                ref_regs[dest] = result;
                compare_value("debug_wb_pc", debug_wb_pc, ref_pc);
                compare_value("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(dest));
                compare_value("debug_wb_rf_wdata", debug_wb_rf_wdata, result);
                done = 1'b1;
            end
            ref_pc = next_pc;
            steps++;
            if (!done && steps >= 64) begin
                other_errors++;
                $display("reference model ran 64 instructions without a register write");
                done = 1'b1;
            end
        end
    endtask

    task automatic print_counts();
        $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 checks, value_errors, other_errors, cpu_top_inst.cpu_props_inst.assert_fails);
    endtask

    // both srams answer one cycle after the request
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= imem[inst_sram_addr[9:2]];
        end
        if (data_sram_en) begin
            for (int b = 0; b < 4; b++) begin
                if (data_sram_wen[b]) begin
                    dmem[data_sram_addr[7:2]][8*b +: 8] = data_sram_wdata[8*b +: 8];
                end
            end
            data_sram_rdata <= dmem[data_sram_addr[7:2]];
        end
    end

    // data port accesses queue up until the model reaches them
    always @(posedge clk) begin
        if (arst_n) begin
            // instruction port reads every cycle
            compare_value("inst_sram_en", 32'(inst_sram_en), 32'h1);
            if (data_sram_en) begin
                access_q.push_back({data_sram_wen, data_sram_addr, data_sram_wdata});
            end
            if (debug_wb_rf_wen != 4'h0) begin
                follow_retirement();
                retired++;
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with only %0d of %0d retirements",
                 cycle_count, retired, retire_target);
        print_counts();
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        arst_n          = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        lfsr_state      = 32'd76474;
        retired         = 0;
        checks          = 0;
        value_errors    = 0;
        other_errors    = 0;
        ref_pc          = reset_pc;
        for (int i = 0; i < 256; i++) begin
            imem[i] = make_instruction(i);
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i]     = {8'hd0, 8'(i), 8'(~i), 8'(i * 5)};
            ref_dmem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        while (retired < retire_target) begin
            @(posedge clk);
        end
        print_counts();
        if (value_errors == 0 && other_errors == 0 &&
            cpu_top_inst.cpu_props_inst.assert_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
logic/cpu_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/exe_stage.sv
logic/wb_stage.sv
logic/cpu_top.sv
verif/cpu_props.sv
verif/cpu_tb.sv
